// File: Makefile
# Verilator build and run for the PPS sync project
VERILATOR ?= verilator
TOP       ?= pps_sync_tb
RTL_TOP   ?= pps_sync_top
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?=

RTL_FILES = common/sync_pkg.sv source/pps_validator.sv source/sync_nco.sv \
            source/phase_detector.sv source/lock_ctrl.sv source/pps_sync_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) $(VFLAGS)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) --lint-only +incdir+common $(RTL_FILES) --top-module $(RTL_TOP) $(VFLAGS)

clean:
	rm -rf $(BUILD_DIR)

// File: common/sync_defines.svh
/*
 Clock counts are in cycles of the single system clk.
 The values are simulation defaults. On the board PPS_PERIOD_CLKS would be 40000000.
 SYNC_PER_PPS must divide PPS_PERIOD_CLKS exactly.
 Step and lock limits must stay well below half a SYNC period.
*/
`ifndef SYNC_DEFINES_SVH
`define SYNC_DEFINES_SVH

// nominal clks between pps rising edges
`define PPS_PERIOD_CLKS 20000
// allowed +- deviation of one pps interval
`define PPS_TOL_CLKS 100

// sync periods per pps interval
`define SYNC_PER_PPS 20
// nominal sync period, 1000 clks with the defaults
`define SYNC_PERIOD_CLKS (`PPS_PERIOD_CLKS / `SYNC_PER_PPS)

// raw pps rise to pps_tick: 2 sync flops + edge flop
`define PPS_LATENCY 3

// largest phase step per pps while acquiring
`define CORR_STEP_MAX 64
// |error| that still counts as locked
`define LOCK_TOL_CLKS 2
// consecutive good pps before lock
`define LOCK_COUNT 3

`endif

// File: common/sync_pkg.sv
/*
 Types shared by the PPS sync blocks.
 The widths are fixed and sized for the board value of PPS_PERIOD_CLKS.
 phase_err_t holds both phase errors and phase steps.
*/
`default_nettype none

package sync_pkg;

  // pps interval counter, covers 40 MHz * 1 s plus tolerance
  typedef logic [31:0] pps_cnt_t;

  // sync phase count, 0 at the sync rise
  typedef logic [15:0] phase_t;

  // signed error or step, positive = sync late / advance sync
  typedef logic signed [16:0] phase_err_t;

  // loop state
  typedef enum logic [1:0]
  {
    IDLE    = 2'd0, // no valid pps, manual nudges allowed
    ACQUIRE = 2'd1, // bounded steps
    TRACK   = 2'd2  // small full corrections, locked
  } lock_state_t;

endpackage

`default_nettype wire

// File: dv/pps_sync_tb.sv
/*
 Trace-driven testbench for the PPS sync top level.
 Expects to run from the project root so that the trace path resolves.
 Trace column values of 2 for valid or locked mean that the flag is not checked.
*/
`timescale 1ns/10ps
`default_nettype none
`include "sync_defines.svh"

module pps_sync_tb;

  localparam int per_nom = `SYNC_PERIOD_CLKS;
  localparam int int_lo  = `PPS_PERIOD_CLKS - `PPS_TOL_CLKS;
  localparam int int_hi  = `PPS_PERIOD_CLKS + `PPS_TOL_CLKS;

  logic             clk;
  logic             rst_n;
  logic             pps;
  logic             faster;
  logic             slower;
  logic             sync;
  logic             sync_wrap;
  sync_pkg::phase_t phase;
  logic             pps_valid;
  logic             locked;

  // trace columns
  int tr_ival[$];
  int tr_width[$];
  int tr_fast[$];
  int tr_slow[$];
  int tr_valid[$];
  int tr_lock[$];
  int tr_mode[$];

  // monitor state, written on posedge only
  int   cyc = 0;
  int   rise_count = 0;
  int   last_sync_rise = 0;
  int   sync_rises[$];
  logic sync_prev = 1'b0;
  // set from the main loop
  int   period_mode = 0;  // 0 nominal only, 1 bounded steps
  int   adj_idx = -1;     // rise index that ends a manually trimmed period
  int   adj_val = 0;
  logic trace_loaded = 1'b0;
  int   run_limit = 0;
  integer seed = 32'h1555_9ccc;

  pps_sync_top pps_sync_top_i
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .pps       (pps),
    .faster    (faster),
    .slower    (slower),
    .sync      (sync),
    .sync_wrap (sync_wrap),
    .phase     (phase),
    .pps_valid (pps_valid),
    .locked    (locked)
  );

  always #10 clk = ~clk; // 20 ns period

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAIL %s got=%h exp=%h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic stop_with(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "run aborted");
  endtask

  // sync edge monitor, sees pre-update values at posedge
  always @(posedge clk)
  begin
    int rise;
    int per;
    int dev;
    cyc = cyc + 1;
    if (rst_n)
    begin
      check("sync_wrap", sync_wrap, sync & ~sync_prev); // wrap pulse marks the rise
      if (sync && !sync_prev)
      begin
        rise = cyc - 1; // rise happened at the previous posedge
        check("phase_at_rise", phase, 0);
        if (rise_count > 0)
        begin
          per = rise - last_sync_rise;
          dev = (per > per_nom) ? per - per_nom : per_nom - per;
          if (rise_count == adj_idx)
            check("sync_period_trim", per, per_nom + adj_val);
          else if (period_mode == 0)
            check("sync_period", per, per_nom);
          else
            check("sync_period_in_bound", dev <= `CORR_STEP_MAX, 1);
        end
        last_sync_rise = rise;
        rise_count     = rise_count + 1;
        sync_rises.push_back(rise);
      end
    end
    sync_prev = sync;
  end

  // time limit from the trace length
  initial
  begin
    wait (trace_loaded);
    repeat (run_limit) @(posedge clk);
    stop_with("watchdog expired before the trace finished");
  end

  task automatic load_trace();
    int    fd;
    int    n;
    int    v[7];
    string line;
    fd = $fopen("dv/pps_sync_trace.txt", "r");
    if (fd == 0)
      stop_with("cannot open trace file dv/pps_sync_trace.txt");
    while (!$feof(fd))
    begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 1 && line.getc(0) != "#") // skip comments and blanks
      begin
        n = $sscanf(line, "%d %d %d %d %d %d %d", v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
        if (n != 7)
          stop_with("malformed line in trace file");
        tr_ival.push_back(v[0]);
        tr_width.push_back(v[1]);
        tr_fast.push_back(v[2]);
        tr_slow.push_back(v[3]);
        tr_valid.push_back(v[4]);
        tr_lock.push_back(v[5]);
        tr_mode.push_back(v[6]);
      end
    end
    $fclose(fd);
  endtask

  // nearest sync rise to a pps rise, in clks
  function automatic int nearest_rise_dist(input int at);
    int best;
    int d;
    best = 32'h7fff_ffff;
    foreach (sync_rises[k])
    begin
      d = (sync_rises[k] > at) ? sync_rises[k] - at : at - sync_rises[k];
      if (d < best)
        best = d;
    end
    return best;
  endfunction

  initial
  begin
    int   ival;
    int   strobed;
    int   prev_in_tol;
    int   align_req;
    int   align_cyc;
    int   total;
    clk    = 1'b0;
    rst_n  = 1'b0;
    pps    = 1'b0;
    faster = 1'b0;
    slower = 1'b0;
    prev_in_tol = 0;
    align_req   = 0;
    align_cyc   = 0;

    load_trace();
    total = 32;
    foreach (tr_ival[i])
      total = total + tr_ival[i] + 1; // +1 for jitter
    run_limit    = total + 10 * per_nom;
    trace_loaded = 1'b1;

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    foreach (tr_ival[i])
    begin
      ival = tr_ival[i];
      if (tr_width[i] > 0 && ival > int_lo && ival < int_hi)
        ival = ival + ($random(seed) % 2); // -1..1
      align_req = 0;
      if (tr_width[i] > 0)
      begin
        if (locked && prev_in_tol)
        begin
          align_req = 1; // previous interval clean, lock held
          align_cyc = cyc;
        end
        pps = 1'b1;
      end
      period_mode = tr_mode[i];
      strobed = 0;
      for (int c = 0; c < ival; c++)
      begin
        if (c == tr_width[i])
          pps = 1'b0;
        faster = 1'b0;
        slower = 1'b0;
        if ((tr_fast[i] || tr_slow[i]) && !strobed && rise_count > 0 &&
            cyc == last_sync_rise + 5)
        begin
          // trim lands on the period after the next rise
          adj_idx = rise_count + 1;
          adj_val = tr_fast[i] ? -1 : 1;
          faster  = tr_fast[i][0];
          slower  = tr_slow[i][0];
          strobed = 1;
        end
        if (c == ival - 1)
        begin
          if (tr_valid[i] != 2)
            check("pps_valid", pps_valid, tr_valid[i]);
          if (tr_lock[i] != 2)
            check("locked", locked, tr_lock[i]);
          if (align_req)
            check("sync_pps_aligned", nearest_rise_dist(align_cyc) <= `LOCK_TOL_CLKS + 1, 1);
        end
        @(negedge clk);
      end
      if ((tr_fast[i] || tr_slow[i]) && !strobed)
        stop_with("manual strobe could not be placed in its trace line");
      prev_in_tol = (tr_width[i] > 0) && (ival >= int_lo) && (ival <= int_hi);
    end

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/pps_sync_trace.txt
# interval_clks pps_width faster slower exp_valid exp_locked period_mode
# width 0 = no pps rise; exp 2 = not checked; mode 0 = nominal sync, 1 = bounded steps
1400 0 0 0 0 0 0
4000 0 1 0 0 0 0
4000 0 0 1 0 0 0
20000 200 0 0 0 0 1
20000 200 0 0 1 0 1
20000 200 0 0 1 0 1
20000 200 0 0 1 0 1
20000 200 0 0 1 2 1
20000 200 0 0 1 2 1
20000 200 0 0 1 2 1
20000 200 0 0 1 2 1
20000 200 0 0 1 2 1
20000 200 0 0 1 2 1
20000 200 0 0 1 2 1
20000 200 0 0 1 2 1
20000 200 0 0 1 2 1
20000 200 0 0 1 1 1
20000 200 0 0 1 1 1
20000 200 0 0 1 1 1
20000 200 0 0 1 1 1
19700 200 0 0 1 1 1
20000 200 0 0 0 0 1
20000 200 0 0 1 0 1
20000 200 0 0 1 2 1
20000 200 0 0 1 2 1
20000 200 0 0 1 2 1
20000 200 0 0 1 2 1
20000 200 0 0 1 2 1
20000 200 0 0 1 2 1
20000 200 0 0 1 2 1
20000 200 0 0 1 2 1
20000 200 0 0 1 2 1
20000 200 0 0 1 1 1
20000 200 0 0 1 1 1
20000 200 0 0 1 1 1
200 0 0 0 0 0 1
6000 0 0 0 0 0 0

// File: sim.f
+incdir+common
common/sync_pkg.sv
source/pps_validator.sv
source/sync_nco.sv
source/phase_detector.sv
source/lock_ctrl.sv
source/pps_sync_top.sv
dv/pps_sync_tb.sv

// File: source/lock_ctrl.sv
/*
 Phase loop control with IDLE, ACQUIRE and TRACK states.
 ACQUIRE clips each step to +-CORR_STEP_MAX, and TRACK applies small errors in full.
 Lock needs LOCK_COUNT consecutive errors within LOCK_TOL_CLKS.
 The faster and slower inputs act only in IDLE, each as a one-clk nudge.
*/
`timescale 1ns/10ps
`default_nettype none
`include "sync_defines.svh"

module lock_ctrl
(
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       pps_valid,
  input  wire                       pps_lost,
  input  wire sync_pkg::phase_err_t phase_err,
  input  wire                       err_strobe,
  input  wire                       faster,     // manual nudges
  input  wire                       slower,
  output sync_pkg::phase_err_t      step,
  output logic                      trim_req,
  output logic                      locked,
  output sync_pkg::lock_state_t     state
);

  localparam sync_pkg::phase_err_t step_max  = sync_pkg::phase_err_t'(`CORR_STEP_MAX);
  localparam sync_pkg::phase_err_t lock_tol  = sync_pkg::phase_err_t'(`LOCK_TOL_CLKS);
  localparam logic [7:0]           good_last = 8'(`LOCK_COUNT - 1);

  logic                 err_small;
  sync_pkg::phase_err_t err_clip;
  logic [7:0]           good_cnt;  // consecutive small errors

  assign err_small = (phase_err <= lock_tol) && (phase_err >= -lock_tol);

  // bounded step for acquisition
  always_comb
  begin
    if (phase_err > step_max)
      err_clip = step_max;
    else if (phase_err < -step_max)
      err_clip = -step_max;
    else
      err_clip = phase_err;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= sync_pkg::IDLE;
      locked   <= 1'b0;
      trim_req <= 1'b0;
      step     <= '0;
      good_cnt <= '0;
    end
    else
    begin
      trim_req <= 1'b0; // pulse

      if ((state != sync_pkg::IDLE) && (pps_lost || !pps_valid))
      begin
        // lost reference, sync free-runs at nominal
        state    <= sync_pkg::IDLE;
        locked   <= 1'b0;
        good_cnt <= '0;
      end
      else
      begin
        case (state)
          sync_pkg::IDLE:
          begin
            if (err_strobe && pps_valid)
            begin
              state    <= sync_pkg::ACQUIRE;
              step     <= err_clip;
              trim_req <= 1'b1;
              good_cnt <= err_small ? 8'd1 : 8'd0;
            end
            else if (faster)
            begin
              step     <= sync_pkg::phase_err_t'(1); // one clk earlier
              trim_req <= 1'b1;
            end
            else if (slower)
            begin
              step     <= sync_pkg::phase_err_t'(-1); // one clk later
              trim_req <= 1'b1;
            end
          end

          sync_pkg::ACQUIRE:
          begin
            if (err_strobe)
            begin
              step     <= err_clip;
              trim_req <= 1'b1;
              if (!err_small)
                good_cnt <= '0;
              else if (good_cnt >= good_last)
              begin
                state    <= sync_pkg::TRACK;
                locked   <= 1'b1;
                good_cnt <= '0;
              end
              else
                good_cnt <= good_cnt + 1'b1;
            end
          end

          sync_pkg::TRACK:
          begin
            if (err_strobe)
            begin
              trim_req <= 1'b1;
              if (err_small)
                step <= phase_err; // full correction, already small
              else
              begin
                state  <= sync_pkg::ACQUIRE;
                locked <= 1'b0;
                step   <= err_clip;
              end
            end
          end

          default:
            state <= sync_pkg::IDLE;
        endcase
      end
    end
  end

  a_lock_track : assert property (@(posedge clk) disable iff (!rst_n)
    locked |-> (state == sync_pkg::TRACK))
    else $error("locked outside TRACK");

endmodule

`default_nettype wire

// File: source/phase_detector.sv
/*
 Samples the SYNC phase at each pps_tick and removes the tick latency.
 An error of zero means that the SYNC rise lines up with the raw PPS rise.
 A positive error means that SYNC lags, and the range is -P/2 .. P/2-1.
 A period stretched by a trim is folded back modulo the nominal period.
*/
`timescale 1ns/10ps
`default_nettype none
`include "sync_defines.svh"

module phase_detector
(
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   pps_tick,
  input  wire sync_pkg::phase_t phase,
  output sync_pkg::phase_err_t  phase_err,  // held until next sample
  output logic                  err_strobe  // 1 clk after pps_tick
);

  localparam sync_pkg::phase_err_t sync_period = sync_pkg::phase_err_t'(`SYNC_PERIOD_CLKS);
  localparam sync_pkg::phase_err_t half_period =
    sync_pkg::phase_err_t'(`SYNC_PERIOD_CLKS / 2);
  localparam sync_pkg::phase_err_t pps_latency = sync_pkg::phase_err_t'(`PPS_LATENCY);

  sync_pkg::phase_err_t ph_at_pps; // sync phase at the raw pps rise
  sync_pkg::phase_err_t lag;       // clks until the next sync rise, folded

  always_comb
  begin
    ph_at_pps = sync_pkg::phase_err_t'(phase) - pps_latency;
    if (ph_at_pps < 0)
      ph_at_pps = ph_at_pps + sync_period;
    else if (ph_at_pps >= sync_period)
      ph_at_pps = ph_at_pps - sync_period; // stretched period
    // sync rose ph_at_pps clks early, i.e. lags by P - ph_at_pps
    lag = (ph_at_pps == 0) ? '0 : sync_period - ph_at_pps;
    if (lag >= half_period)
      lag = lag - sync_period; // nearer rise was before the pps
  end

  // sampled error, read only under err_strobe
  always_ff @(posedge clk)
  begin
    if (pps_tick)
      phase_err <= lag;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      err_strobe <= 1'b0;
    else
      err_strobe <= pps_tick;
  end

endmodule

`default_nettype wire

// File: source/pps_sync_top.sv
/*
 PPS-disciplined SYNC generator for an accelerometer with an external SYNC input.
 Everything runs on clk. pps may be asynchronous to it.
 faster and slower must be one-clk pulses synchronous to clk.
 The loop only steps the phase, so the SYNC rate stays nominal.
*/
`timescale 1ns/10ps
`default_nettype none

module pps_sync_top
(
  input  wire              clk,
  input  wire              rst_n,
  input  wire              pps,        // rising edge sensitive
  input  wire              faster,     // one-clk phase nudge in IDLE
  input  wire              slower,
  output logic             sync,       // to accelerometer SYNC
  output logic             sync_wrap,
  output sync_pkg::phase_t phase,      // phase monitor
  output logic             pps_valid,
  output logic             locked
);

  logic                 pps_tick;
  logic                 pps_lost;
  sync_pkg::phase_err_t phase_err;
  logic                 err_strobe;
  sync_pkg::phase_err_t step;
  logic                 trim_req;

  pps_validator pps_validator_i
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .pps       (pps),
    .pps_tick  (pps_tick),
    .pps_valid (pps_valid),
    .pps_lost  (pps_lost)
  );

  sync_nco sync_nco_i
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .step      (step),
    .trim_req  (trim_req),
    .phase     (phase),
    .sync      (sync),
    .sync_wrap (sync_wrap)
  );

  phase_detector phase_detector_i
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .pps_tick   (pps_tick),
    .phase      (phase),
    .phase_err  (phase_err),
    .err_strobe (err_strobe)
  );

  lock_ctrl lock_ctrl_i
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .pps_valid  (pps_valid),
    .pps_lost   (pps_lost),
    .phase_err  (phase_err),
    .err_strobe (err_strobe),
    .faster     (faster),
    .slower     (slower),
    .step       (step),
    .trim_req   (trim_req),
    .locked     (locked),
    .state      ()            // loop state for debug probing
  );

endmodule

`default_nettype wire

// File: source/pps_validator.sv
/*
 The pps input is asynchronous and only its rising edge is used.
 pps_tick lags the raw rise by exactly PPS_LATENCY clocks.
 pps_valid needs one full in-tolerance interval after the first edge.
 pps_lost fires once per outage, and then a new edge must re-arm.
*/
`timescale 1ns/10ps
`default_nettype none
`include "sync_defines.svh"

module pps_validator
(
  input  wire  clk,
  input  wire  rst_n,
  input  wire  pps,        // raw and async
  output logic pps_tick,   // 1 clk per rising edge
  output logic pps_valid,
  output logic pps_lost    // 1 clk when the interval overran
);

  localparam sync_pkg::pps_cnt_t cnt_lo =
    sync_pkg::pps_cnt_t'(`PPS_PERIOD_CLKS - `PPS_TOL_CLKS);
  localparam sync_pkg::pps_cnt_t cnt_hi =
    sync_pkg::pps_cnt_t'(`PPS_PERIOD_CLKS + `PPS_TOL_CLKS);

  logic [1:0]          pps_sync_q;   // [0] may go metastable
  logic                pps_prev;     // delayed synced pps for edge detect
  sync_pkg::pps_cnt_t  interval_cnt; // clks since last tick
  logic                armed;        // an edge has been seen
  logic                in_tol;

  // count equals the interval length on the tick cycle
  assign in_tol = (interval_cnt >= cnt_lo) && (interval_cnt <= cnt_hi);

  // synchronizer and edge flop
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pps_sync_q <= 2'b00;
      pps_prev   <= 1'b0;
      pps_tick   <= 1'b0;
    end
    else
    begin
      pps_sync_q <= {pps_sync_q[0], pps};
      pps_prev   <= pps_sync_q[1];
      pps_tick   <= pps_sync_q[1] & ~pps_prev; // rising edge only
    end
  end

  // interval check
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      interval_cnt <= '0;
      armed        <= 1'b0;
      pps_valid    <= 1'b0;
      pps_lost     <= 1'b0;
    end
    else if (pps_tick)
    begin
      interval_cnt <= sync_pkg::pps_cnt_t'(1); // tick cycle counts as 1
      armed        <= 1'b1;
      pps_valid    <= armed & in_tol; // first edge only arms
      pps_lost     <= 1'b0;
    end
    else
    begin
      if (interval_cnt <= cnt_hi)
        interval_cnt <= interval_cnt + 1'b1; // parks at cnt_hi + 1
      pps_lost <= armed && (interval_cnt == cnt_hi); // once per outage
      if (pps_lost)
      begin
        armed     <= 1'b0;
        pps_valid <= 1'b0;
      end
    end
  end

  // tick lags the raw rise by the latency that phase_detector takes off
  a_tick_latency : assert property (@(posedge clk) disable iff (!rst_n)
    pps_tick |-> $past(pps, `PPS_LATENCY) && !$past(pps, `PPS_LATENCY + 1))
    else $error("pps_tick not %0d clks after a pps rise", `PPS_LATENCY);

endmodule

`default_nettype wire

// File: source/sync_nco.sv
/*
 Counter oscillator for the SYNC output. Only the phase can be corrected, not the rate.
 A trim takes effect at the next wrap and lasts for one period.
 A new trim that arrives before that wrap replaces the pending one.
 sync is high for the first half of the nominal period and rises with phase 0.
*/
`timescale 1ns/10ps
`default_nettype none
`include "sync_defines.svh"

module sync_nco
(
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire sync_pkg::phase_err_t step,     // + shortens one period
  input  wire                  trim_req,
  output sync_pkg::phase_t     phase,
  output logic                 sync,
  output logic                 sync_wrap       // 1 clk at phase 0
);

  localparam sync_pkg::phase_t period_nom = sync_pkg::phase_t'(`SYNC_PERIOD_CLKS);
  localparam sync_pkg::phase_t half_nom   = sync_pkg::phase_t'(`SYNC_PERIOD_CLKS / 2);
  localparam sync_pkg::phase_t len_min    =
    sync_pkg::phase_t'(`SYNC_PERIOD_CLKS - `CORR_STEP_MAX);
  localparam sync_pkg::phase_t len_max    =
    sync_pkg::phase_t'(`SYNC_PERIOD_CLKS + `CORR_STEP_MAX);

  sync_pkg::phase_t     period_len;  // length of the running period
  sync_pkg::phase_err_t pend_step;   // latched trim
  logic                 pend_vld;
  sync_pkg::phase_err_t trimmed_len;
  logic                 wrap;

  assign wrap        = (phase == period_len - 1'b1);
  assign trimmed_len = sync_pkg::phase_err_t'(`SYNC_PERIOD_CLKS) - pend_step;

  // pending trim value
  always_ff @(posedge clk)
  begin
    if (trim_req)
      pend_step <= step;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase      <= '0;
      period_len <= period_nom;
      pend_vld   <= 1'b0;
      sync       <= 1'b0; // stays low until the first wrap
      sync_wrap  <= 1'b0;
    end
    else
    begin
      sync_wrap <= wrap;
      if (wrap)
      begin
        phase      <= '0;
        sync       <= 1'b1;
        // one trimmed period then back to nominal
        period_len <= pend_vld ? sync_pkg::phase_t'(trimmed_len) : period_nom;
      end
      else
      begin
        phase <= phase + 1'b1;
        if (phase + 1'b1 == half_nom)
          sync <= 1'b0; // half of nominal even in trimmed periods
      end

      // a trim on the wrap cycle waits for the next wrap
      if (trim_req)
        pend_vld <= 1'b1;
      else if (wrap)
        pend_vld <= 1'b0;
    end
  end

  // bounded by the step clipping in lock_ctrl
  a_len_bound : assert property (@(posedge clk) disable iff (!rst_n)
    (period_len >= len_min) && (period_len <= len_max))
    else $error("sync period length %0d out of bounds", period_len);

endmodule

`default_nettype wire
